/* tb.f */
design/cpu_bus_pkg.sv
design/cpu_isa_pkg.sv
design/bus_master.sv
design/sequencer.sv
design/alu.sv
design/register_file.sv
design/cpu_top.sv
dv/cpu_properties.sv
dv/tb_checker.sv
dv/tb_top.sv

/* Makefile */
LOG := sim.log

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module tb_top -o sim

run: build
	./obj_dir/sim > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Verification failed" $(LOG); then exit 1; fi

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module tb_top

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

/* dv/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    logic               clk;
    logic               reset;
    logic               mem_req;
    logic               mem_we;
    cpu_bus_pkg::addr_t mem_addr;
    cpu_bus_pkg::data_t mem_wdata;
    logic               mem_ack;
    cpu_bus_pkg::data_t mem_rdata;
    logic               done;
    int                 fail_count;

    logic [7:0]         mem [0:65535];
    logic [7:0]         valid_ops [0:11];
    integer             seed;
    int                 wait_cnt;
    int                 hold_cnt;
    int                 cycles;

    cpu_top UUT
    (
        .clk, .reset, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
    );

    tb_checker u_checker
    (
        .clk, .reset, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack,
        .done, .fail_count
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    function automatic logic is_valid_op(input logic [7:0] op);
        is_valid_op = 1'b0;
        for (int k = 0; k < 12; k++)
        begin
            if (valid_ops[k] == op)
            begin
                is_valid_op = 1'b1;
            end
        end
    endfunction

    // builds a random program at 0100 that ends in a jump to itself
    task automatic build_program();
        logic [15:0] pc;
        logic [15:0] target;
        logic [7:0]  op;
        int          kind;
        int          skip;
        pc = 16'h0100;
        for (int i = 0; i < 60; i++)
        begin
            kind = $unsigned($random(seed)) % 13;
            if (kind < 12)
            begin
                op = valid_ops[kind];
            end
            else
            begin
                op = 8'h00;
                while (is_valid_op(op))
                begin
                    op = 8'($random(seed));
                end
            end
            mem[pc] = op;
            pc = pc + 16'd1;
            if (kind >= 1 && kind <= 7)
            begin
                mem[pc] = 8'($random(seed));
                pc = pc + 16'd1;
            end
            else if (kind >= 8 && kind <= 10)
            begin
                mem[pc] = 8'($random(seed));
                mem[pc + 16'd1] = 8'h80;
                pc = pc + 16'd2;
            end
            else if (kind == 11)
            begin
                // jump forward over a few filler bytes
                skip = $unsigned($random(seed)) % 4;
                target = pc + 16'd2 + 16'(skip);
                mem[pc] = target[7:0];
                mem[pc + 16'd1] = target[15:8];
                for (int s = 0; s < skip; s++)
                begin
                    mem[pc + 16'd2 + 16'(s)] = 8'($random(seed));
                end
                pc = target;
            end
        end
        mem[pc] = cpu_isa_pkg::OP_JP_ABS;
        mem[pc + 16'd1] = pc[7:0];
        mem[pc + 16'd2] = pc[15:8];
    endtask

    initial
    begin
        seed = 32'h21aebe38;
        reset = 1'b1;
        mem_ack = 1'b0;
        mem_rdata = '0;
        wait_cnt = 0;
        hold_cnt = 0;
        valid_ops[0] = cpu_isa_pkg::OP_NOP;
        valid_ops[1] = cpu_isa_pkg::OP_LD_A_IMM;
        valid_ops[2] = cpu_isa_pkg::OP_LD_B_IMM;
        valid_ops[3] = cpu_isa_pkg::OP_ADD_IMM;
        valid_ops[4] = cpu_isa_pkg::OP_SUB_IMM;
        valid_ops[5] = cpu_isa_pkg::OP_AND_IMM;
        valid_ops[6] = cpu_isa_pkg::OP_OR_IMM;
        valid_ops[7] = cpu_isa_pkg::OP_XOR_IMM;
        valid_ops[8] = cpu_isa_pkg::OP_LD_A_ABS;
        valid_ops[9] = cpu_isa_pkg::OP_ST_A_ABS;
        valid_ops[10] = cpu_isa_pkg::OP_ST_B_ABS;
        valid_ops[11] = cpu_isa_pkg::OP_JP_ABS;
        for (int a = 0; a < 65536; a++)
        begin
            mem[a] = a[7:0] ^ a[15:8] ^ 8'h5a;
        end
        // reset vector points to 0100
        mem[0] = 8'h00;
        mem[1] = 8'h01;
        for (int a = 16'h8000; a <= 16'h80ff; a++)
        begin
            mem[a] = 8'($random(seed));
        end
        build_program();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        while (!done && cycles < 200000)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!done)
        begin
            $display("timeout: the checker did not finish the program");
            $display("Verification failed");
        end
        else if (fail_count == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

    // memory answers after 0 to 3 idle cycles and drops ack 0 to 3 cycles after req is gone
    always @(posedge clk)
    begin
        if (mem_ack)
        begin
            if (!mem_req && hold_cnt == 0)
            begin
                mem_ack <= 1'b0;
                wait_cnt <= $unsigned($random(seed)) % 4;
                hold_cnt <= $unsigned($random(seed)) % 4;
            end
            else if (!mem_req)
            begin
                hold_cnt <= hold_cnt - 1;
            end
        end
        else if (mem_req && !reset)
        begin
            if (wait_cnt == 0)
            begin
                mem_ack <= 1'b1;
                mem_rdata <= mem[mem_addr];
                if (mem_we)
                begin
                    mem[mem_addr] <= mem_wdata;
                end
            end
            else
            begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

/* dv/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker
(
    input  logic               clk,
    input  logic               reset,
    input  logic               mem_req,
    input  logic               mem_we,
    input  cpu_bus_pkg::addr_t mem_addr,
    input  cpu_bus_pkg::data_t mem_wdata,
    input  logic               mem_ack,
    output logic               done,
    output int                 fail_count
);
    logic [7:0]  img [0:65535];
    logic [7:0]  ma;
    logic [7:0]  mb;
    logic [15:0] mpc;
    logic [15:0] op_addr;
    logic [15:0] ea;
    logic [7:0]  op;
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic [7:0]  d;
    logic        timed_out;
    logic        prev_unknown;
    int          err [1:5];
    int          self_jumps;
    int          unknown_count;
    int          transfers;
    int          instrs;
    int          npass;

    // one transfer is seen in the single cycle where req and ack are both high
    task automatic wait_transfer(output logic [15:0] a, output logic we, output logic [7:0] wd);
        int cyc;
        logic got;
        cyc = 0;
        got = 1'b0;
        a = '0;
        we = 1'b0;
        wd = '0;
        while (!got && cyc < 200)
        begin
            @(posedge clk);
            cyc++;
            if (mem_req && mem_ack)
            begin
                got = 1'b1;
                a = mem_addr;
                we = mem_we;
                wd = mem_wdata;
            end
        end
        if (!got)
        begin
            $display("no bus transfer completed within 200 cycles");
            timed_out = 1'b1;
        end
        transfers++;
    endtask

    task automatic expect_read(input logic [15:0] exp, input int test, output logic [7:0] data);
        logic [15:0] a;
        logic        we;
        logic [7:0]  wd;
        wait_transfer(a, we, wd);
        data = img[exp];
        if (!timed_out)
        begin
            if (we)
            begin
                $display("[ERROR] mem_we: expected %h, got %h at %h", 1'b0, we, a);
                err[test]++;
            end
            if (a !== exp)
            begin
                $display("[ERROR] mem_addr: expected %h, got %h", exp, a);
                err[test]++;
            end
        end
    endtask

    task automatic expect_write(input logic [15:0] exp, input logic [7:0] val);
        logic [15:0] a;
        logic        we;
        logic [7:0]  wd;
        wait_transfer(a, we, wd);
        img[exp] = val;
        if (!timed_out)
        begin
            if (!we || a !== exp)
            begin
                $display("[ERROR] mem_addr/mem_we: expected %h/1, got %h/%h", exp, a, we);
                err[3]++;
            end
            if (wd !== val)
            begin
                $display("[ERROR] mem_wdata: expected %h, got %h", val, wd);
                err[3]++;
            end
        end
    endtask

    initial
    begin
        done = 1'b0;
        fail_count = 0;
        timed_out = 1'b0;
        prev_unknown = 1'b0;
        self_jumps = 0;
        unknown_count = 0;
        transfers = 0;
        instrs = 0;
        for (int t = 1; t <= 5; t++)
        begin
            err[t] = 0;
        end
        while (reset !== 1'b0 && instrs < 1000)
        begin
            @(posedge clk);
            instrs++;
        end
        instrs = 0;
        for (int i = 0; i < 65536; i++)
        begin
            img[i] = tb_top.mem[i];
        end
        ma = '0;
        mb = '0;
        expect_read(cpu_bus_pkg::RESET_VECTOR_DEFAULT, 1, lo);
        expect_read(cpu_bus_pkg::RESET_VECTOR_DEFAULT + 16'd1, 1, hi);
        mpc = {hi, lo};
        while (!timed_out && self_jumps < 4 && instrs < 2000)
        begin
            op_addr = mpc;
            expect_read(mpc, prev_unknown ? 5 : (instrs == 0 ? 1 : 2), op);
            prev_unknown = 1'b0;
            instrs++;
            mpc = mpc + 16'd1;
            case (op)
                cpu_isa_pkg::OP_NOP:
                begin
                end
                cpu_isa_pkg::OP_LD_A_IMM, cpu_isa_pkg::OP_LD_B_IMM,
                cpu_isa_pkg::OP_ADD_IMM, cpu_isa_pkg::OP_SUB_IMM,
                cpu_isa_pkg::OP_AND_IMM, cpu_isa_pkg::OP_OR_IMM,
                cpu_isa_pkg::OP_XOR_IMM:
                begin
                    expect_read(mpc, 2, d);
                    mpc = mpc + 16'd1;
                    case (op)
                        cpu_isa_pkg::OP_LD_A_IMM: ma = d;
                        cpu_isa_pkg::OP_LD_B_IMM: mb = d;
                        cpu_isa_pkg::OP_ADD_IMM:  ma = ma + d;
                        cpu_isa_pkg::OP_SUB_IMM:  ma = ma - d;
                        cpu_isa_pkg::OP_AND_IMM:  ma = ma & d;
                        cpu_isa_pkg::OP_OR_IMM:   ma = ma | d;
                        default:                  ma = ma ^ d;
                    endcase
                end
                cpu_isa_pkg::OP_LD_A_ABS, cpu_isa_pkg::OP_ST_A_ABS,
                cpu_isa_pkg::OP_ST_B_ABS, cpu_isa_pkg::OP_JP_ABS:
                begin
                    expect_read(mpc, 2, lo);
                    expect_read(mpc + 16'd1, 2, hi);
                    mpc = mpc + 16'd2;
                    ea = {hi, lo};
                    if (op == cpu_isa_pkg::OP_LD_A_ABS)
                    begin
                        expect_read(ea, 2, d);
                        ma = d;
                    end
                    else if (op == cpu_isa_pkg::OP_ST_A_ABS)
                    begin
                        expect_write(ea, ma);
                    end
                    else if (op == cpu_isa_pkg::OP_ST_B_ABS)
                    begin
                        expect_write(ea, mb);
                    end
                    else
                    begin
                        if (ea == op_addr)
                        begin
                            self_jumps++;
                        end
                        mpc = ea;
                    end
                end
                default:
                begin
                    // anything else behaves like NOP
                    unknown_count++;
                    prev_unknown = 1'b1;
                end
            endcase
        end
        if (timed_out || self_jumps < 4)
        begin
            $display("the program did not reach its final self-jump");
            err[4]++;
        end
        if (unknown_count == 0)
        begin
            $display("the program held no opcode outside the instruction set");
            err[5]++;
        end
        npass = 0;
        for (int t = 1; t <= 5; t++)
        begin
            if (err[t] == 0)
            begin
                npass++;
            end
        end
        $display("test 1 reset vector and first fetch: %s", err[1] == 0 ? "PASS" : "FAIL");
        $display("test 2 read addresses: %s", err[2] == 0 ? "PASS" : "FAIL");
        $display("test 3 store data: %s", err[3] == 0 ? "PASS" : "FAIL");
        $display("test 4 program completion: %s", err[4] == 0 ? "PASS" : "FAIL");
        $display("test 5 unknown opcodes (%0d): %s", unknown_count,
                 err[5] == 0 ? "PASS" : "FAIL");
        $display("tests passed: %0d, failed: %0d, transfers checked: %0d",
                 npass, 5 - npass, transfers);
        fail_count = 5 - npass;
        done = 1'b1;
    end

endmodule

/* dv/cpu_properties.sv */
`timescale 1ns/1ps

module cpu_properties
(
    input logic               clk,
    input logic               reset,
    input logic               mem_req,
    input logic               mem_we,
    input cpu_bus_pkg::addr_t mem_addr,
    input cpu_bus_pkg::data_t mem_wdata,
    input logic               mem_ack
);

    // request fields hold for as long as req stays up
    assert property (@(posedge clk) disable iff (reset)
        (mem_req && $past(mem_req)) |->
            ($stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata)))
        else $error("request fields changed while mem_req was high");

    assert property (@(posedge clk) disable iff (reset)
        $fell(mem_req) |-> $past(mem_ack))
        else $error("mem_req fell before mem_ack");

    assert property (@(posedge clk) disable iff (reset)
        $rose(mem_req) |-> !$past(mem_ack))
        else $error("mem_req rose while mem_ack was high");

endmodule

bind bus_master cpu_properties u_cpu_properties
(
    .clk, .reset, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack
);

/* design/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top
#(
    parameter cpu_bus_pkg::addr_t RESET_VECTOR = cpu_bus_pkg::RESET_VECTOR_DEFAULT
)
(
    input  logic               clk,
    input  logic               reset,
    output logic               mem_req,
    output logic               mem_we,
    output cpu_bus_pkg::addr_t mem_addr,
    output cpu_bus_pkg::data_t mem_wdata,
    input  logic               mem_ack,
    input  cpu_bus_pkg::data_t mem_rdata
);
    logic                  xfer_start;
    logic                  xfer_we;
    cpu_bus_pkg::addr_t    xfer_addr;
    cpu_bus_pkg::data_t    xfer_wdata;
    logic                  xfer_done;
    cpu_bus_pkg::data_t    xfer_rdata;
    logic                  pc_inc;
    logic                  pc_load;
    cpu_bus_pkg::addr_t    pc_load_value;
    cpu_bus_pkg::addr_t    pc;
    cpu_bus_pkg::data_t    reg_a;
    cpu_bus_pkg::data_t    reg_b;
    logic                  exec_valid;
    cpu_isa_pkg::alu_op_t  alu_op;
    cpu_isa_pkg::reg_sel_t alu_dst;
    cpu_bus_pkg::data_t    alu_operand;
    logic                  wb_valid;
    cpu_isa_pkg::reg_sel_t wb_dst;
    cpu_bus_pkg::data_t    wb_data;

    bus_master u_bus_master
    (
        .clk, .reset, .xfer_start, .xfer_we, .xfer_addr, .xfer_wdata, .xfer_done,
        .xfer_rdata, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
    );

    sequencer #(.RESET_VECTOR(RESET_VECTOR)) u_sequencer
    (
        .clk, .reset, .xfer_start, .xfer_we, .xfer_addr, .xfer_wdata, .xfer_done,
        .xfer_rdata, .pc, .reg_a, .reg_b, .pc_inc, .pc_load, .pc_load_value,
        .exec_valid, .alu_op, .alu_dst, .alu_operand
    );

    alu u_alu
    (
        .clk, .reset, .exec_valid, .alu_op, .alu_dst, .alu_operand, .reg_a,
        .wb_valid, .wb_dst, .wb_data
    );

    register_file u_register_file
    (
        .clk, .reset, .wb_valid, .wb_dst, .wb_data, .pc_inc, .pc_load,
        .pc_load_value, .reg_a, .reg_b, .pc
    );

endmodule

/* design/register_file.sv */
`timescale 1ns/1ps

module register_file
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wb_valid,
    input  cpu_isa_pkg::reg_sel_t wb_dst,
    input  cpu_bus_pkg::data_t    wb_data,
    input  logic                  pc_inc,
    input  logic                  pc_load,
    input  cpu_bus_pkg::addr_t    pc_load_value,
    output cpu_bus_pkg::data_t    reg_a,
    output cpu_bus_pkg::data_t    reg_b,
    output cpu_bus_pkg::addr_t    pc
);

    // a write-back with no destination leaves both registers alone
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            reg_a <= '0;
            reg_b <= '0;
        end
        else if (wb_valid)
        begin
            case (wb_dst)
                cpu_isa_pkg::REG_A:
                    reg_a <= wb_data;
                cpu_isa_pkg::REG_B:
                    reg_b <= wb_data;
                default:
                begin
                end
            endcase
        end
    end

    // a jump or vector load wins over the increment
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            pc <= '0;
        end
        else if (pc_load)
        begin
            pc <= pc_load_value;
        end
        else if (pc_inc)
        begin
            pc <= pc + 16'd1;
        end
    end

endmodule

/* design/alu.sv */
`timescale 1ns/1ps

module alu
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  exec_valid,
    input  cpu_isa_pkg::alu_op_t  alu_op,
    input  cpu_isa_pkg::reg_sel_t alu_dst,
    input  cpu_bus_pkg::data_t    alu_operand,
    input  cpu_bus_pkg::data_t    reg_a,
    output logic                  wb_valid,
    output cpu_isa_pkg::reg_sel_t wb_dst,
    output cpu_bus_pkg::data_t    wb_data
);
    cpu_bus_pkg::data_t result;

    // results wrap at 8 bits and no flags are kept
    always_comb
    begin
        case (alu_op)
            cpu_isa_pkg::ALU_ADD:
                result = reg_a + alu_operand;
            cpu_isa_pkg::ALU_SUB:
                result = reg_a - alu_operand;
            cpu_isa_pkg::ALU_AND:
                result = reg_a & alu_operand;
            cpu_isa_pkg::ALU_OR:
                result = reg_a | alu_operand;
            cpu_isa_pkg::ALU_XOR:
                result = reg_a ^ alu_operand;
            default:
                result = alu_operand;
        endcase
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            wb_valid <= 1'b0;
        end
        else
        begin
            wb_valid <= exec_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (exec_valid)
        begin
            wb_dst  <= alu_dst;
            wb_data <= result;
        end
    end

endmodule

/* design/sequencer.sv */
`timescale 1ns/1ps

module sequencer
#(
    parameter cpu_bus_pkg::addr_t RESET_VECTOR = cpu_bus_pkg::RESET_VECTOR_DEFAULT
)
(
    input  logic                   clk,
    input  logic                   reset,
    output logic                   xfer_start,
    output logic                   xfer_we,
    output cpu_bus_pkg::addr_t     xfer_addr,
    output cpu_bus_pkg::data_t     xfer_wdata,
    input  logic                   xfer_done,
    input  cpu_bus_pkg::data_t     xfer_rdata,
    input  cpu_bus_pkg::addr_t     pc,
    input  cpu_bus_pkg::data_t     reg_a,
    input  cpu_bus_pkg::data_t     reg_b,
    output logic                   pc_inc,
    output logic                   pc_load,
    output cpu_bus_pkg::addr_t     pc_load_value,
    output logic                   exec_valid,
    output cpu_isa_pkg::alu_op_t   alu_op,
    output cpu_isa_pkg::reg_sel_t  alu_dst,
    output cpu_bus_pkg::data_t     alu_operand
);
    cpu_isa_pkg::seq_state_t state;
    cpu_isa_pkg::opcode_t    opcode;
    cpu_bus_pkg::data_t      imm_lo;
    cpu_bus_pkg::data_t      imm_hi;
    logic                    in_flight;
    logic                    is_mem_op;
    logic                    is_jump;

    // gives how many operand bytes follow an opcode and none for unknown opcodes
    function automatic logic [1:0] imm_count(input cpu_isa_pkg::opcode_t op);
        case (op)
            cpu_isa_pkg::OP_LD_A_IMM, cpu_isa_pkg::OP_LD_B_IMM,
            cpu_isa_pkg::OP_ADD_IMM, cpu_isa_pkg::OP_SUB_IMM,
            cpu_isa_pkg::OP_AND_IMM, cpu_isa_pkg::OP_OR_IMM,
            cpu_isa_pkg::OP_XOR_IMM:
                imm_count = 2'd1;
            cpu_isa_pkg::OP_LD_A_ABS, cpu_isa_pkg::OP_ST_A_ABS,
            cpu_isa_pkg::OP_ST_B_ABS, cpu_isa_pkg::OP_JP_ABS:
                imm_count = 2'd2;
            default:
                imm_count = 2'd0;
        endcase
    endfunction

    assign is_mem_op = (opcode == cpu_isa_pkg::OP_LD_A_ABS) ||
                       (opcode == cpu_isa_pkg::OP_ST_A_ABS) ||
                       (opcode == cpu_isa_pkg::OP_ST_B_ABS);
    assign is_jump   = (opcode == cpu_isa_pkg::OP_JP_ABS);

    always_comb
    begin
        case (state)
            cpu_isa_pkg::ST_VEC_LO:
                xfer_addr = RESET_VECTOR;
            cpu_isa_pkg::ST_VEC_HI:
                xfer_addr = RESET_VECTOR + 16'd1;
            cpu_isa_pkg::ST_MEM:
                xfer_addr = {imm_hi, imm_lo};
            default:
                xfer_addr = pc;
        endcase
    end

    assign xfer_we    = (state == cpu_isa_pkg::ST_MEM) && (opcode != cpu_isa_pkg::OP_LD_A_ABS);
    assign xfer_wdata = (opcode == cpu_isa_pkg::OP_ST_B_ABS) ? reg_b : reg_a;

    // PC moves past each opcode and operand byte as it is taken from the bus
    assign pc_inc = xfer_done && ((state == cpu_isa_pkg::ST_FETCH) ||
                                  (state == cpu_isa_pkg::ST_IMM_LO) ||
                                  (state == cpu_isa_pkg::ST_IMM_HI));
    assign pc_load = (xfer_done && state == cpu_isa_pkg::ST_VEC_HI) ||
                     (state == cpu_isa_pkg::ST_EXEC && is_jump);
    // the low vector byte is parked in imm_lo until the high byte arrives
    assign pc_load_value = (state == cpu_isa_pkg::ST_VEC_HI) ? {xfer_rdata, imm_lo} :
                                                               {imm_hi, imm_lo};
    assign exec_valid = (state == cpu_isa_pkg::ST_EXEC);

    always_comb
    begin
        alu_op      = cpu_isa_pkg::ALU_PASS;
        alu_dst     = cpu_isa_pkg::REG_NONE;
        alu_operand = imm_lo;
        case (opcode)
            cpu_isa_pkg::OP_LD_A_IMM:
                alu_dst = cpu_isa_pkg::REG_A;
            cpu_isa_pkg::OP_LD_B_IMM:
                alu_dst = cpu_isa_pkg::REG_B;
            cpu_isa_pkg::OP_ADD_IMM:
            begin
                alu_op  = cpu_isa_pkg::ALU_ADD;
                alu_dst = cpu_isa_pkg::REG_A;
            end
            cpu_isa_pkg::OP_SUB_IMM:
            begin
                alu_op  = cpu_isa_pkg::ALU_SUB;
                alu_dst = cpu_isa_pkg::REG_A;
            end
            cpu_isa_pkg::OP_AND_IMM:
            begin
                alu_op  = cpu_isa_pkg::ALU_AND;
                alu_dst = cpu_isa_pkg::REG_A;
            end
            cpu_isa_pkg::OP_OR_IMM:
            begin
                alu_op  = cpu_isa_pkg::ALU_OR;
                alu_dst = cpu_isa_pkg::REG_A;
            end
            cpu_isa_pkg::OP_XOR_IMM:
            begin
                alu_op  = cpu_isa_pkg::ALU_XOR;
                alu_dst = cpu_isa_pkg::REG_A;
            end
            // the loaded byte is still held on the read data of the bus master
            cpu_isa_pkg::OP_LD_A_ABS:
            begin
                alu_dst     = cpu_isa_pkg::REG_A;
                alu_operand = xfer_rdata;
            end
            default:
            begin
            end
        endcase
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state      <= cpu_isa_pkg::ST_VEC_LO;
            in_flight  <= 1'b0;
            xfer_start <= 1'b0;
        end
        else
        begin
            xfer_start <= 1'b0;
            // every state except execute owns exactly one bus transfer
            if (state != cpu_isa_pkg::ST_EXEC && !in_flight)
            begin
                xfer_start <= 1'b1;
                in_flight  <= 1'b1;
            end
            if (xfer_done)
            begin
                in_flight <= 1'b0;
                case (state)
                    cpu_isa_pkg::ST_VEC_LO:
                        state <= cpu_isa_pkg::ST_VEC_HI;
                    cpu_isa_pkg::ST_VEC_HI:
                        state <= cpu_isa_pkg::ST_FETCH;
                    cpu_isa_pkg::ST_FETCH:
                        state <= (imm_count(xfer_rdata) == 2'd0) ? cpu_isa_pkg::ST_EXEC :
                                                                   cpu_isa_pkg::ST_IMM_LO;
                    cpu_isa_pkg::ST_IMM_LO:
                        state <= (imm_count(opcode) == 2'd2) ? cpu_isa_pkg::ST_IMM_HI :
                                                               cpu_isa_pkg::ST_EXEC;
                    cpu_isa_pkg::ST_IMM_HI:
                        state <= is_mem_op ? cpu_isa_pkg::ST_MEM : cpu_isa_pkg::ST_EXEC;
                    default:
                        state <= cpu_isa_pkg::ST_EXEC;
                endcase
            end
            else if (state == cpu_isa_pkg::ST_EXEC)
            begin
                state <= cpu_isa_pkg::ST_FETCH;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (xfer_done)
        begin
            case (state)
                cpu_isa_pkg::ST_FETCH:
                    opcode <= xfer_rdata;
                cpu_isa_pkg::ST_VEC_LO, cpu_isa_pkg::ST_IMM_LO:
                    imm_lo <= xfer_rdata;
                cpu_isa_pkg::ST_IMM_HI:
                    imm_hi <= xfer_rdata;
                default:
                begin
                end
            endcase
        end
    end

endmodule

/* design/bus_master.sv */
`timescale 1ns/1ps

module bus_master
(
    input  logic               clk,
    input  logic               reset,
    input  logic               xfer_start,
    input  logic               xfer_we,
    input  cpu_bus_pkg::addr_t xfer_addr,
    input  cpu_bus_pkg::data_t xfer_wdata,
    output logic               xfer_done,
    output cpu_bus_pkg::data_t xfer_rdata,
    output logic               mem_req,
    output logic               mem_we,
    output cpu_bus_pkg::addr_t mem_addr,
    output cpu_bus_pkg::data_t mem_wdata,
    input  logic               mem_ack,
    input  cpu_bus_pkg::data_t mem_rdata
);
    typedef enum logic [1:0]
    {
        PH_IDLE,
        PH_REQ,
        PH_REL
    } phase_t;

    phase_t phase;
    logic   pending;
    logic   launch;

    // a request goes out only from idle, which the release phase leaves once ack is low
    assign launch = (phase == PH_IDLE) && (xfer_start || pending);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            phase     <= PH_IDLE;
            pending   <= 1'b0;
            mem_req   <= 1'b0;
            mem_we    <= 1'b0;
            xfer_done <= 1'b0;
        end
        else
        begin
            xfer_done <= 1'b0;
            // a start that arrives while ack is still high waits here
            pending <= (pending || xfer_start) && !launch;
            if (xfer_start)
            begin
                mem_we <= xfer_we;
            end
            case (phase)
                PH_REQ:
                begin
                    if (mem_ack)
                    begin
                        mem_req   <= 1'b0;
                        xfer_done <= 1'b1;
                        phase     <= PH_REL;
                    end
                end
                default:
                begin
                    if (launch)
                    begin
                        mem_req <= 1'b1;
                        phase   <= PH_REQ;
                    end
                    else if (!mem_ack)
                    begin
                        phase <= PH_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (xfer_start)
        begin
            mem_addr  <= xfer_addr;
            mem_wdata <= xfer_wdata;
        end
        // read data stays put until the next transfer is acknowledged
        if (phase == PH_REQ && mem_ack)
        begin
            xfer_rdata <= mem_rdata;
        end
    end

endmodule

/* design/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    // every opcode is a single byte and operand bytes follow low byte first
    typedef logic [7:0] opcode_t;

    localparam opcode_t OP_NOP      = 8'h00;
    localparam opcode_t OP_LD_A_IMM = 8'h10;
    localparam opcode_t OP_LD_B_IMM = 8'h11;
    localparam opcode_t OP_ADD_IMM  = 8'h20;
    localparam opcode_t OP_SUB_IMM  = 8'h21;
    localparam opcode_t OP_AND_IMM  = 8'h22;
    localparam opcode_t OP_OR_IMM   = 8'h23;
    localparam opcode_t OP_XOR_IMM  = 8'h24;
    localparam opcode_t OP_LD_A_ABS = 8'h30;
    localparam opcode_t OP_ST_A_ABS = 8'h31;
    localparam opcode_t OP_ST_B_ABS = 8'h32;
    localparam opcode_t OP_JP_ABS   = 8'h40;

    // PASS forwards the operand unchanged and the rest combine A with the operand
    typedef enum logic [2:0]
    {
        ALU_PASS,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    typedef enum logic [1:0]
    {
        REG_NONE,
        REG_A,
        REG_B
    } reg_sel_t;

    typedef enum logic [2:0]
    {
        ST_VEC_LO,
        ST_VEC_HI,
        ST_FETCH,
        ST_IMM_LO,
        ST_IMM_HI,
        ST_MEM,
        ST_EXEC
    } seq_state_t;

endpackage

/* design/cpu_bus_pkg.sv */
package cpu_bus_pkg;

    // byte address on the external memory bus
    typedef logic [15:0] addr_t;

    // one byte of memory or register data
    typedef logic [7:0] data_t;

    // the low vector byte sits here and the high byte at the next address
    localparam addr_t RESET_VECTOR_DEFAULT = 16'h0000;

endpackage
